// ==== hdl/dcache_cfg_pkg.sv ====
//####################################################################
// Data cache geometry: address and word widths, byte enables and the
// helpers that split a byte address into tag, line index and word offset
//####################################################################
`default_nettype none

package dcache_cfg_pkg;

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned SEL_W      = DATA_W / 8;
  // Byte position inside one word
  localparam int unsigned BYTE_OFF_W = $clog2(SEL_W);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  sel_t;

  // off_w and idx_w are log2 of words per line and of line count
  function automatic addr_t word_offset(addr_t addr, int unsigned off_w);
    addr_t mask;
    mask = (addr_t'(1) << off_w) - addr_t'(1);
    return (addr >> BYTE_OFF_W) & mask;
  endfunction

  function automatic addr_t line_index(addr_t addr, int unsigned off_w,
                                       int unsigned idx_w);
    addr_t mask;
    mask = (addr_t'(1) << idx_w) - addr_t'(1);
    return (addr >> (BYTE_OFF_W + off_w)) & mask;
  endfunction

  function automatic addr_t line_tag(addr_t addr, int unsigned off_w, int unsigned idx_w);
    return addr >> (BYTE_OFF_W + off_w + idx_w);
  endfunction

  // Word-aligned byte address rebuilt from its three fields
  function automatic addr_t line_addr(addr_t tag, addr_t index, addr_t offset,
                                      int unsigned off_w, int unsigned idx_w);
    return (tag << (BYTE_OFF_W + off_w + idx_w)) | (index << (BYTE_OFF_W + off_w)) |
           (offset << BYTE_OFF_W);
  endfunction

endpackage

`default_nettype wire

// ==== hdl/dcache_if_pkg.sv ====
//####################################################################
// Port structs of the data cache towards the LSU and the data memory,
// and the state encoding of the cache controller
//####################################################################
`default_nettype none

package dcache_if_pkg;

  // LSU request, held stable until ack
  typedef struct packed {
    logic                  req;
    logic                  w_en;
    dcache_cfg_pkg::addr_t addr;
    dcache_cfg_pkg::data_t w_data;
    dcache_cfg_pkg::sel_t  sel_byte;
  } lsummu2dcache_t;

  // LSU response, ack and flush_ack are single cycle pulses
  typedef struct packed {
    logic                  ack;
    logic                  flush_ack;
    dcache_cfg_pkg::data_t r_data;
  } dcache2lsummu_t;

  // One word per req/ack exchange
  typedef struct packed {
    logic                  req;
    logic                  w_en;
    dcache_cfg_pkg::addr_t addr;
    dcache_cfg_pkg::data_t w_data;
  } dcache2mem_t;

  typedef struct packed {
    logic                  ack;
    dcache_cfg_pkg::data_t r_data;
  } mem2dcache_t;

  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    WRBACK,
    REFILL,
    FLUSH_SCAN,
    FLUSH_WRBACK,
    FLUSH_DONE
  } dcache_state_e;

endpackage

`default_nettype wire

// ==== hdl/wb_dcache_controller.sv ====
//####################################################################
// Control FSM of the write-back data cache: hits, write-back and refill
// of a line on a miss, full flush and kill of a memory transaction
//####################################################################
`default_nettype none

module wb_dcache_controller #(
  parameter  int unsigned NUM_LINES  = 16,
  parameter  int unsigned LINE_WORDS = 4,
  localparam int unsigned OFF_BITS   = $clog2(LINE_WORDS),
  localparam int unsigned IDX_BITS   = $clog2(NUM_LINES),
  localparam int unsigned OFF_W      = (OFF_BITS > 0) ? OFF_BITS : 1,
  localparam int unsigned IDX_W      = (IDX_BITS > 0) ? IDX_BITS : 1
) (
  input  wire logic             clk,
  input  wire logic             rst_n_i,
  input  wire logic             dmem_sel_i,
  input  wire logic             dcache_flush_i,
  input  wire logic             dcache_kill_i,
  input  wire logic             lsu_req_i,
  input  wire logic             lsu_wr_i,
  input  wire logic             cache_hit_i,
  input  wire logic             cache_dirty_i,
  input  wire logic             line_dirty_i,
  input  wire logic             mem_ack_i,
  output logic                  lsu_ack_o,
  output logic                  flush_ack_o,
  output logic                  mem_req_o,
  output logic                  mem_wr_o,
  output logic                  mem_kill_o,
  output logic                  cache_wr_o,
  output logic                  refill_wr_o,
  output logic                  line_validate_o,
  output logic                  line_clean_o,
  output logic                  wrb_sel_o,
  output logic [OFF_W-1:0]      word_cnt_o,
  output logic [IDX_W-1:0]      flush_index_o
);

  dcache_if_pkg::dcache_state_e state_q, state_d;
  logic                         mem_req_q, mem_req_d;
  logic                         kill_q;
  logic [OFF_W-1:0]             word_cnt_q, word_cnt_d;
  logic [IDX_W-1:0]             flush_idx_q, flush_idx_d;
  logic                         last_word;
  logic                         last_line;
  logic                         mem_done;
  logic                         abort;

  assign last_word = (word_cnt_q == OFF_W'(LINE_WORDS - 1));
  assign last_line = (flush_idx_q == IDX_W'(NUM_LINES - 1));
  assign mem_done  = mem_req_q & mem_ack_i;

  // Kill only matters while a miss is talking to memory
  assign abort = dcache_kill_i &&
                 (state_q == dcache_if_pkg::WRBACK || state_q == dcache_if_pkg::REFILL);

  always_comb begin
    state_d         = state_q;
    mem_req_d       = mem_req_q;
    word_cnt_d      = word_cnt_q;
    flush_idx_d     = flush_idx_q;
    lsu_ack_o       = 1'b0;
    flush_ack_o     = 1'b0;
    cache_wr_o      = 1'b0;
    refill_wr_o     = 1'b0;
    line_validate_o = 1'b0;
    line_clean_o    = 1'b0;

    unique case (state_q)
      dcache_if_pkg::IDLE: begin
        word_cnt_d  = '0;
        flush_idx_d = '0;
        if (dcache_flush_i) begin
          state_d = dcache_if_pkg::FLUSH_SCAN;
        end else if (lsu_req_i && dmem_sel_i) begin
          state_d = dcache_if_pkg::COMPARE;
        end
      end

      dcache_if_pkg::COMPARE: begin
        if (!lsu_req_i) begin
          state_d = dcache_if_pkg::IDLE;
        end else if (cache_hit_i) begin
          lsu_ack_o  = 1'b1;
          cache_wr_o = lsu_wr_i;
          state_d    = dcache_if_pkg::IDLE;
        end else begin
          state_d = cache_dirty_i ? dcache_if_pkg::WRBACK : dcache_if_pkg::REFILL;
        end
      end

      // Victim goes out word by word, req drops for a cycle after each ack
      dcache_if_pkg::WRBACK: begin
        if (abort) begin
          mem_req_d  = 1'b0;
          word_cnt_d = '0;
          state_d    = dcache_if_pkg::IDLE;
        end else if (mem_done) begin
          mem_req_d  = 1'b0;
          word_cnt_d = word_cnt_q + 1'b1;
          if (last_word) begin
            line_clean_o = 1'b1;
            word_cnt_d   = '0;
            state_d      = dcache_if_pkg::REFILL;
          end
        end else begin
          mem_req_d = 1'b1;
        end
      end

      dcache_if_pkg::REFILL: begin
        if (abort) begin
          mem_req_d  = 1'b0;
          word_cnt_d = '0;
          state_d    = dcache_if_pkg::IDLE;
        end else if (mem_done) begin
          refill_wr_o = 1'b1;
          mem_req_d   = 1'b0;
          word_cnt_d  = word_cnt_q + 1'b1;
          if (last_word) begin
            line_validate_o = 1'b1;
            word_cnt_d      = '0;
            state_d         = dcache_if_pkg::COMPARE;
          end
        end else begin
          mem_req_d = 1'b1;
        end
      end

      dcache_if_pkg::FLUSH_SCAN: begin
        if (line_dirty_i) begin
          state_d = dcache_if_pkg::FLUSH_WRBACK;
        end else if (last_line) begin
          state_d = dcache_if_pkg::FLUSH_DONE;
        end else begin
          flush_idx_d = flush_idx_q + 1'b1;
        end
      end

      // Back to the scan on the same index, which now reads clean
      dcache_if_pkg::FLUSH_WRBACK: begin
        if (mem_done) begin
          mem_req_d  = 1'b0;
          word_cnt_d = word_cnt_q + 1'b1;
          if (last_word) begin
            line_clean_o = 1'b1;
            word_cnt_d   = '0;
            state_d      = dcache_if_pkg::FLUSH_SCAN;
          end
        end else begin
          mem_req_d = 1'b1;
        end
      end

      dcache_if_pkg::FLUSH_DONE: begin
        flush_ack_o = 1'b1;
        state_d     = dcache_if_pkg::IDLE;
      end

      default: state_d = dcache_if_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q     <= dcache_if_pkg::IDLE;
      mem_req_q   <= 1'b0;
      kill_q      <= 1'b0;
      word_cnt_q  <= '0;
      flush_idx_q <= '0;
    end else begin
      state_q     <= state_d;
      mem_req_q   <= mem_req_d;
      kill_q      <= abort;
      word_cnt_q  <= word_cnt_d;
      flush_idx_q <= flush_idx_d;
    end
  end

  assign mem_req_o     = mem_req_q;
  assign mem_wr_o      = (state_q == dcache_if_pkg::WRBACK) ||
                         (state_q == dcache_if_pkg::FLUSH_WRBACK);
  assign mem_kill_o    = kill_q;
  assign wrb_sel_o     = (state_q == dcache_if_pkg::FLUSH_SCAN) ||
                         (state_q == dcache_if_pkg::FLUSH_WRBACK);
  assign word_cnt_o    = word_cnt_q;
  assign flush_index_o = flush_idx_q;

endmodule

`default_nettype wire

// ==== hdl/wb_dcache_datapath.sv ====
//####################################################################
// Storage of the data cache: tag, valid, dirty and data arrays, hit
// detection, byte merge of stores and the address of memory transfers
//####################################################################
`default_nettype none

module wb_dcache_datapath #(
  parameter  int unsigned NUM_LINES  = 16,
  parameter  int unsigned LINE_WORDS = 4,
  localparam int unsigned OFF_BITS   = $clog2(LINE_WORDS),
  localparam int unsigned IDX_BITS   = $clog2(NUM_LINES),
  localparam int unsigned OFF_W      = (OFF_BITS > 0) ? OFF_BITS : 1,
  localparam int unsigned IDX_W      = (IDX_BITS > 0) ? IDX_BITS : 1
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire dcache_cfg_pkg::addr_t lsu_addr_i,
  input  wire dcache_cfg_pkg::data_t lsu_wdata_i,
  input  wire dcache_cfg_pkg::sel_t  sel_byte_i,
  input  wire dcache_cfg_pkg::data_t mem_rdata_i,
  input  wire logic                  cache_wr_i,
  input  wire logic                  refill_wr_i,
  input  wire logic                  line_validate_i,
  input  wire logic                  line_clean_i,
  input  wire logic                  wrb_sel_i,
  input  wire logic [OFF_W-1:0]      word_cnt_i,
  input  wire logic [IDX_W-1:0]      flush_index_i,
  output logic                       cache_hit_o,
  output logic                       cache_dirty_o,
  output logic                       line_dirty_o,
  output dcache_cfg_pkg::data_t      lsu_rdata_o,
  output dcache_cfg_pkg::addr_t      mem_addr_o,
  output dcache_cfg_pkg::data_t      mem_wdata_o
);

  localparam int unsigned TAG_W = dcache_cfg_pkg::ADDR_W - dcache_cfg_pkg::BYTE_OFF_W -
                                  OFF_BITS - IDX_BITS;

  logic [TAG_W-1:0]      tag_q [NUM_LINES];
  logic [NUM_LINES-1:0]  valid_q;
  logic [NUM_LINES-1:0]  dirty_q;
  dcache_cfg_pkg::data_t data_q [NUM_LINES][LINE_WORDS];

  logic [TAG_W-1:0]      req_tag;
  logic [IDX_W-1:0]      req_idx;
  logic [OFF_W-1:0]      req_off;
  logic [IDX_W-1:0]      vic_idx;
  logic                  vic_dirty;
  logic [TAG_W-1:0]      mem_tag;
  dcache_cfg_pkg::data_t merged;

  assign req_tag = TAG_W'(dcache_cfg_pkg::line_tag(lsu_addr_i, OFF_BITS, IDX_BITS));
  assign req_idx = IDX_W'(dcache_cfg_pkg::line_index(lsu_addr_i, OFF_BITS, IDX_BITS));
  assign req_off = OFF_W'(dcache_cfg_pkg::word_offset(lsu_addr_i, OFF_BITS));

  assign cache_hit_o   = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign cache_dirty_o = valid_q[req_idx] & dirty_q[req_idx];
  assign line_dirty_o  = valid_q[flush_index_i] & dirty_q[flush_index_i];

  // Flush walks its own index, a miss works on the request index
  assign vic_idx   = wrb_sel_i ? flush_index_i : req_idx;
  assign vic_dirty = valid_q[vic_idx] & dirty_q[vic_idx];

  // A dirty line is still being written back, so its own tag addresses memory.
  // Once cleaned, the refill fetches the requested tag.
  assign mem_tag = vic_dirty ? tag_q[vic_idx] : req_tag;

  assign mem_addr_o = dcache_cfg_pkg::line_addr(dcache_cfg_pkg::addr_t'(mem_tag),
                                                dcache_cfg_pkg::addr_t'(vic_idx),
                                                dcache_cfg_pkg::addr_t'(word_cnt_i),
                                                OFF_BITS, IDX_BITS);
  assign mem_wdata_o = data_q[vic_idx][word_cnt_i];
  assign lsu_rdata_o = data_q[req_idx][req_off];

  // Store data replaces only the enabled bytes
  always_comb begin
    merged = data_q[req_idx][req_off];
    for (int b = 0; b < dcache_cfg_pkg::SEL_W; b++) begin
      if (sel_byte_i[b]) begin
        merged[8*b +: 8] = lsu_wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cache_wr_i) begin
      data_q[req_idx][req_off] <= merged;
    end else if (refill_wr_i) begin
      data_q[req_idx][word_cnt_i] <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (line_validate_i) begin
      tag_q[req_idx] <= req_tag;
    end
  end

  // A line stays invalid from its first refill word until the last one,
  // so an aborted refill never leaves mixed data visible
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (refill_wr_i) begin
        valid_q[req_idx] <= 1'b0;
      end
      if (line_validate_i) begin
        valid_q[req_idx] <= 1'b1;
        dirty_q[req_idx] <= 1'b0;
      end
      if (line_clean_i) begin
        dirty_q[vic_idx] <= 1'b0;
      end
      if (cache_wr_i) begin
        dirty_q[req_idx] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wb_dcache_top.sv ====
//####################################################################
// Write-back direct-mapped data cache between the LSU and data memory,
// set NUM_LINES and LINE_WORDS here
//####################################################################
`default_nettype none

module wb_dcache_top #(
  parameter  int unsigned NUM_LINES  = 16,
  parameter  int unsigned LINE_WORDS = 4,
  localparam int unsigned OFF_W      = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1,
  localparam int unsigned IDX_W      = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1
) (
  input  wire logic                          clk,
  input  wire logic                          rst_n_i,
  input  wire logic                          dmem_sel_i,
  input  wire logic                          dcache_flush_i,
  input  wire logic                          dcache_kill_i,
  input  wire dcache_if_pkg::lsummu2dcache_t lsummu2dcache_i,
  output dcache_if_pkg::dcache2lsummu_t      dcache2lsummu_o,
  input  wire dcache_if_pkg::mem2dcache_t    mem2dcache_i,
  output dcache_if_pkg::dcache2mem_t         dcache2mem_o,
  output logic                               dcache2mem_kill_o
);

  // Controller and datapath strobes
  logic                  cache_hit;
  logic                  cache_dirty;
  logic                  line_dirty;
  logic                  cache_wr;
  logic                  refill_wr;
  logic                  line_validate;
  logic                  line_clean;
  logic                  wrb_sel;
  logic [OFF_W-1:0]      word_cnt;
  logic [IDX_W-1:0]      flush_index;

  logic                  lsu_ack;
  logic                  flush_ack;
  dcache_cfg_pkg::data_t lsu_rdata;
  logic                  mem_req;
  logic                  mem_wr;
  dcache_cfg_pkg::addr_t mem_addr;
  dcache_cfg_pkg::data_t mem_wdata;

  wb_dcache_controller #(
    .NUM_LINES  (NUM_LINES),
    .LINE_WORDS (LINE_WORDS)
  ) i_controller (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .dmem_sel_i      (dmem_sel_i),
    .dcache_flush_i  (dcache_flush_i),
    .dcache_kill_i   (dcache_kill_i),
    .lsu_req_i       (lsummu2dcache_i.req),
    .lsu_wr_i        (lsummu2dcache_i.w_en),
    .cache_hit_i     (cache_hit),
    .cache_dirty_i   (cache_dirty),
    .line_dirty_i    (line_dirty),
    .mem_ack_i       (mem2dcache_i.ack),
    .lsu_ack_o       (lsu_ack),
    .flush_ack_o     (flush_ack),
    .mem_req_o       (mem_req),
    .mem_wr_o        (mem_wr),
    .mem_kill_o      (dcache2mem_kill_o),
    .cache_wr_o      (cache_wr),
    .refill_wr_o     (refill_wr),
    .line_validate_o (line_validate),
    .line_clean_o    (line_clean),
    .wrb_sel_o       (wrb_sel),
    .word_cnt_o      (word_cnt),
    .flush_index_o   (flush_index)
  );

  wb_dcache_datapath #(
    .NUM_LINES  (NUM_LINES),
    .LINE_WORDS (LINE_WORDS)
  ) i_datapath (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .lsu_addr_i      (lsummu2dcache_i.addr),
    .lsu_wdata_i     (lsummu2dcache_i.w_data),
    .sel_byte_i      (lsummu2dcache_i.sel_byte),
    .mem_rdata_i     (mem2dcache_i.r_data),
    .cache_wr_i      (cache_wr),
    .refill_wr_i     (refill_wr),
    .line_validate_i (line_validate),
    .line_clean_i    (line_clean),
    .wrb_sel_i       (wrb_sel),
    .word_cnt_i      (word_cnt),
    .flush_index_i   (flush_index),
    .cache_hit_o     (cache_hit),
    .cache_dirty_o   (cache_dirty),
    .line_dirty_o    (line_dirty),
    .lsu_rdata_o     (lsu_rdata),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata)
  );

  assign dcache2lsummu_o = '{ack: lsu_ack, flush_ack: flush_ack, r_data: lsu_rdata};
  assign dcache2mem_o    = '{req: mem_req, w_en: mem_wr, addr: mem_addr, w_data: mem_wdata};

endmodule

`default_nettype wire

// ==== verification/clk_rst_gen.sv ====
//####################################################################
// Testbench clock with an 8 ns period and an active-low reset that is
// held for the first RST_CYCLES rising edges
//####################################################################
`default_nettype none

module clk_rst_gen #(
  parameter int unsigned RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/wb_dcache_properties.sv ====
//####################################################################
// Handshake and reset assertions, bound into the data cache top level
//####################################################################
`default_nettype none

module wb_dcache_properties (
  input wire logic                          clk,
  input wire logic                          rst_n_i,
  input wire dcache_if_pkg::lsummu2dcache_t lsu_i,
  input wire dcache_if_pkg::dcache2lsummu_t lsu_o,
  input wire dcache_if_pkg::mem2dcache_t    mem_i,
  input wire dcache_if_pkg::dcache2mem_t    mem_o,
  input wire logic                          kill_o
);
  timeunit 1ns;
  timeprecision 100ps;

  ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_o.ack |=> !lsu_o.ack) else $error("LSU ack high for two cycles");

  ack_with_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_o.ack |-> lsu_i.req) else $error("LSU ack without a request");

  // Memory req may only fall after its ack or together with a kill pulse
  mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (mem_o.req && !mem_i.ack) |=> (mem_o.req || kill_o)) else $error("Memory req dropped");

  flush_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    lsu_o.flush_ack |=> !lsu_o.flush_ack) else $error("flush_ack longer than one cycle");

  reset_quiet: assert property (@(posedge clk)
    !rst_n_i |=> !(lsu_o.ack || lsu_o.flush_ack || mem_o.req || kill_o))
    else $error("Control output high after reset");

endmodule

`default_nettype wire

// ==== verification/wb_dcache_tb.sv ====
//####################################################################
// Directed testbench of the write-back data cache with a memory model
// that acks after a random delay and a flat reference model
//####################################################################
`default_nettype none

module wb_dcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MEM_WORDS = 4096;
  localparam int unsigned TIMEOUT   = 2000;

  typedef struct packed {
    logic                  w;
    dcache_cfg_pkg::addr_t a;
  } mem_op_t;

  logic                          clk;
  logic                          rst_n;
  logic                          dmem_sel;
  logic                          flush;
  logic                          kill;
  logic                          mem_kill;
  dcache_if_pkg::lsummu2dcache_t lsu_req;
  dcache_if_pkg::dcache2lsummu_t lsu_rsp;
  dcache_if_pkg::mem2dcache_t    mem_rsp;
  dcache_if_pkg::dcache2mem_t    mem_req;

  dcache_cfg_pkg::data_t mem_q [MEM_WORDS];
  dcache_cfg_pkg::data_t ref_q [MEM_WORDS];
  mem_op_t               mem_log [$];
  logic                  pending;
  logic [1:0]            dly;
  logic [15:0]           lfsr_q = 16'd6;
  int                    mismatch_cnt = 0;
  int                    fail_cnt = 0;

  clk_rst_gen i_clk_rst (.clk_o(clk), .rst_n_o(rst_n));

  wb_dcache_top #(.NUM_LINES(16), .LINE_WORDS(4)) i_dut (
    .clk               (clk),
    .rst_n_i           (rst_n),
    .dmem_sel_i        (dmem_sel),
    .dcache_flush_i    (flush),
    .dcache_kill_i     (kill),
    .lsummu2dcache_i   (lsu_req),
    .dcache2lsummu_o   (lsu_rsp),
    .mem2dcache_i      (mem_rsp),
    .dcache2mem_o      (mem_req),
    .dcache2mem_kill_o (mem_kill)
  );

  bind wb_dcache_top wb_dcache_properties i_props (
    .clk(clk), .rst_n_i(rst_n_i), .lsu_i(lsummu2dcache_i), .lsu_o(dcache2lsummu_o),
    .mem_i(mem2dcache_i), .mem_o(dcache2mem_o), .kill_o(dcache2mem_kill_o)
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic dcache_cfg_pkg::data_t pattern(int unsigned widx);
    return (widx * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  // Memory model, one word per req/ack with a 1 to 4 cycle delay
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_rsp.ack <= 1'b0;
      pending     <= 1'b0;
    end else if (mem_rsp.ack) begin
      mem_rsp.ack <= 1'b0;
    end else if (mem_req.req) begin
      if (!pending) begin
        pending <= 1'b1;
        dly     <= 2'(rand_bits(2));
      end else if (dly == 0) begin
        pending        <= 1'b0;
        mem_rsp.ack    <= 1'b1;
        mem_rsp.r_data <= mem_q[mem_req.addr[13:2]];
        if (mem_req.w_en) begin
          mem_q[mem_req.addr[13:2]] <= mem_req.w_data;
        end
        mem_log.push_back('{w: mem_req.w_en, a: mem_req.addr});
      end else begin
        dly <= dly - 1'b1;
      end
    end else begin
      pending <= 1'b0;
    end
  end

  task automatic compare_data(string name, dcache_cfg_pkg::data_t got,
                              dcache_cfg_pkg::data_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_addr(string name, dcache_cfg_pkg::addr_t got,
                              dcache_cfg_pkg::addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic compare_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic end_run();
    $display("Errors: %0d value mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic timed_out(string what);
    $display("Timeout at %0d ns while waiting for %s", $time, what);
    fail_cnt++;
    end_run();
  endtask

  // One LSU access, returns read data and the cycles until ack
  task automatic access(logic wr, dcache_cfg_pkg::addr_t a, dcache_cfg_pkg::data_t wd,
                        dcache_cfg_pkg::sel_t sel, output dcache_cfg_pkg::data_t rd,
                        output int cycles);
    @(posedge clk);
    lsu_req <= '{req: 1'b1, w_en: wr, addr: a, w_data: wd, sel_byte: sel};
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (lsu_rsp.ack) break;
    end
    if (!lsu_rsp.ack) timed_out("LSU ack");
    rd = lsu_rsp.r_data;
    @(posedge clk);
    lsu_req.req <= 1'b0;
  endtask

  task automatic write_word(dcache_cfg_pkg::addr_t a, dcache_cfg_pkg::data_t wd,
                            dcache_cfg_pkg::sel_t sel);
    dcache_cfg_pkg::data_t rd;
    int                    cycles;
    access(1'b1, a, wd, sel, rd, cycles);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) ref_q[a[13:2]][8*b +: 8] = wd[8*b +: 8];
    end
  endtask

  task automatic read_check(dcache_cfg_pkg::addr_t a, output int cycles);
    dcache_cfg_pkg::data_t rd;
    access(1'b0, a, '0, '0, rd, cycles);
    compare_data($sformatf("r_data @%h", a), rd, ref_q[a[13:2]]);
  endtask

  task automatic read_miss_then_hit();
    int cycles;
    read_check(32'h040, cycles);
    read_check(32'h040, cycles);
    compare_flag("hit latency is 2", cycles == 2, 1'b1);
  endtask

  // A store to a cached line while dmem_sel is low must neither ack nor land
  task automatic unselected_request();
    int   cycles;
    logic saw_ack;
    @(posedge clk);
    dmem_sel <= 1'b0;
    lsu_req  <= '{req: 1'b1, w_en: 1'b1, addr: 32'h040, w_data: 32'hFFFF_FFFF,
                  sel_byte: 4'b1111};
    saw_ack = 1'b0;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      saw_ack |= lsu_rsp.ack;
    end
    compare_flag("LSU ack while dmem_sel low", saw_ack, 1'b0);
    @(posedge clk);
    dmem_sel    <= 1'b1;
    lsu_req.req <= 1'b0;
    read_check(32'h040, cycles);
  endtask

  task automatic byte_writes();
    int cycles;
    write_word(32'h080, 32'h1122_3344, 4'b0001);
    write_word(32'h084, 32'hAABB_CCDD, 4'b1010);
    write_word(32'h088, 32'h0F0F_0F0F, 4'b0110);
    read_check(32'h080, cycles);
    read_check(32'h084, cycles);
    read_check(32'h088, cycles);
  endtask

  task automatic victim_writeback();
    int cycles;
    write_word(32'h0C4, 32'hDEAD_BEEF, 4'b1111);
    mem_log.delete();
    read_check(32'h1C4, cycles);
    compare_flag("memory op count", mem_log.size() == 8, 1'b1);
    for (int i = 0; i < 8 && i < mem_log.size(); i++) begin
      compare_flag("memory op is write", mem_log[i].w, i < 4);
      compare_addr("memory op addr", mem_log[i].a,
                   (i < 4) ? 32'h0C0 + 4 * i : 32'h1C0 + 4 * (i - 4));
    end
    for (int i = 0; i < 4; i++) begin
      compare_data("written back word", mem_q[12'h030 + i], ref_q[12'h030 + i]);
    end
  endtask

  task automatic flush_all();
    int cycles;
    write_word(32'h200, 32'h0123_4567, 4'b1111);
    write_word(32'h314, 32'h89AB_CDEF, 4'b0011);
    write_word(32'h028, 32'h5555_AAAA, 4'b1100);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (lsu_rsp.flush_ack) break;
    end
    if (!lsu_rsp.flush_ack) timed_out("flush_ack");
    for (int i = 0; i < MEM_WORDS; i++) begin
      compare_data($sformatf("memory word %0d", i), mem_q[i], ref_q[i]);
    end
    read_check(32'h314, cycles);
  endtask

  task automatic kill_refill();
    int   cycles;
    logic saw_kill;
    logic saw_ack;
    @(posedge clk);
    lsu_req <= '{req: 1'b1, w_en: 1'b0, addr: 32'h3A0, w_data: '0, sel_byte: '0};
    // Let one refill word complete, then kill on the next request
    cycles = 0;
    while (cycles < TIMEOUT && !mem_rsp.ack) begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_rsp.ack) timed_out("first refill ack");
    cycles = 0;
    while (cycles < TIMEOUT && !(mem_req.req && !mem_rsp.ack)) begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_req.req) timed_out("second refill request");
    @(posedge clk);
    kill        <= 1'b1;
    lsu_req.req <= 1'b0;
    @(posedge clk);
    kill <= 1'b0;
    saw_kill = 1'b0;
    saw_ack  = 1'b0;
    for (int i = 0; i < 12; i++) begin
      @(negedge clk);
      saw_kill |= mem_kill;
      saw_ack  |= lsu_rsp.ack;
    end
    compare_flag("dcache2mem_kill_o pulsed", saw_kill, 1'b1);
    compare_flag("LSU ack after kill", saw_ack, 1'b0);
    read_check(32'h3A0, cycles);
  endtask

  task automatic random_traffic();
    dcache_cfg_pkg::addr_t a;
    int                    cycles;
    for (int n = 0; n < 200; n++) begin
      a = {22'd0, 8'(rand_bits(8)), 2'b00};
      if (rand_bits(1)) begin
        write_word(a, rand_bits(32), 4'(rand_bits(4)));
      end else begin
        read_check(a, cycles);
      end
    end
  endtask

  initial begin
    int cycles;
    dmem_sel = 1'b1;
    flush    = 1'b0;
    kill     = 1'b0;
    lsu_req  = '0;
    mem_rsp  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = pattern(i);
      ref_q[i] = pattern(i);
    end
    cycles = 0;
    while (cycles < 100 && rst_n !== 1'b1) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) timed_out("reset release");
    read_miss_then_hit();
    unselected_request();
    byte_writes();
    victim_writeback();
    flush_all();
    kill_refill();
    random_traffic();
    end_run();
  end

endmodule

`default_nettype wire

// ==== wb_dcache_top.f ====
hdl/dcache_cfg_pkg.sv
hdl/dcache_if_pkg.sv
hdl/wb_dcache_controller.sv
hdl/wb_dcache_datapath.sv
hdl/wb_dcache_top.sv
verification/clk_rst_gen.sv
verification/wb_dcache_properties.sv
verification/wb_dcache_tb.sv
